// ==== filelist.f ====
+incdir+tests
verilog/peTypes.sv
verilog/commandParser.sv
verilog/activationBuffer.sv
verilog/poolEngine.sv
verilog/reluEngine.sv
verilog/resultStreamer.sv
verilog/processingElement.sv
tests/peTestbench.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := peTestbench
FILELIST := filelist.f
BUILD_DIR := obj_dir
PASS_TEXT := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/peModel.svh ====
`ifndef PE_MODEL_SVH
`define PE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model for the two layer types
////////////////////////////////////////////////////////////////////////////

// activations as the host sent them, and the bytes it should get back
logic signed [7:0] modelInput [128];
logic [7:0] modelOutput [128];

// negatives become zero, index order kept
task automatic reluModel(input int size);
  for (int i = 0; i < size; i++) begin
    modelOutput[i] = modelInput[i][7] ? 8'h00 : modelInput[i];
  end
endtask

// one maximum per window, outputs laid out col, row, channel
task automatic poolModel(input int channels, input int outRows, input int outCols,
                         input int windowRows, input int windowCols,
                         input int rowStride, input int colStride);
  int inRows;
  int inCols;
  int index;
  logic signed [7:0] best;
  inRows = (outRows - 1) * rowStride + windowRows;
  inCols = (outCols - 1) * colStride + windowCols;
  for (int ch = 0; ch < channels; ch++) begin
    for (int pr = 0; pr < outRows; pr++) begin
      for (int pc = 0; pc < outCols; pc++) begin
        best = 8'sh80;
        for (int r = 0; r < windowRows; r++) begin
          for (int c = 0; c < windowCols; c++) begin
            index = (pc * colStride + c) + (pr * rowStride + r) * inCols
                    + ch * inRows * inCols;
            if (modelInput[index] > best) begin
              best = modelInput[index];
            end
          end
        end
        modelOutput[pc + pr * outCols + ch * outRows * outCols] = best;
      end
    end
  end
endtask

`endif

// ==== tests/peTestbench.sv ====
`timescale 1ns/1ps

module peTestbench import peTypes::*; ();

  logic clock;
  logic reset;
  streamByte inStream;
  logic inCredit;
  streamByte outStream;
  logic outCreditReturn;

  // host side bookkeeping
  logic [7:0] txQueue [$];
  logic [7:0] rxQueue [$];
  int dueQueue [$];
  int hostInCredits;
  int hostOutCredits;
  int hostCycle;
  bit backPressure;
  int cycleBudget;
  int errorCount;
  int passCount;
  int failCount;

  `include "peModel.svh"

  processingElement DUT (
    .clock(clock),
    .reset(reset),
    .inStream(inStream),
    .inCredit(inCredit),
    .outStream(outStream),
    .outCreditReturn(outCreditReturn)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // host: input credits, output collection, delayed credit returns
  ////////////////////////////////////////////////////////////////////////////

  initial begin : hostSide
    int delay;
    inStream = '0;
    outCreditReturn = 1'b0;
    hostInCredits = inputCredits;
    hostOutCredits = outputCredits;
    hostCycle = 0;
    forever begin
      @(negedge clock);
      hostCycle++;
      if (outStream.valid) begin
        if (hostOutCredits == 0) begin
          $display("ERROR: streamer sent a byte without holding an output credit");
          errorCount++;
        end else begin
          hostOutCredits--;
        end
        rxQueue.push_back(outStream.data);
        // long stalls now and then under back-pressure
        if (backPressure && $urandom_range(0, 3) == 0) begin
          delay = $urandom_range(20, 60);
        end else begin
          delay = $urandom_range(0, 5);
        end
        dueQueue.push_back(hostCycle + delay);
      end
      if (inCredit) begin
        hostInCredits++;
      end
      if (txQueue.size() != 0 && hostInCredits != 0) begin
        inStream.valid = 1'b1;
        inStream.data = txQueue.pop_front();
        hostInCredits--;
      end else begin
        inStream = '0;
      end
      if (dueQueue.size() != 0 && dueQueue[0] <= hostCycle) begin
        outCreditReturn = 1'b1;
        void'(dueQueue.pop_front());
        hostOutCredits++;
      end else begin
        outCreditReturn = 1'b0;
      end
    end
  end

  // limit grows by 20 cycles for every byte queued or expected
  initial begin : watchdog
    int elapsed;
    elapsed = 0;
    while (elapsed <= cycleBudget + 2000) begin
      @(posedge clock);
      elapsed++;
    end
    $display("timeout: the DUT stopped moving bytes after %0d cycles", elapsed);
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic queueByte(input logic [7:0] value);
    txQueue.push_back(value);
    cycleBudget += 20;
  endtask

  task automatic fillInputs(input int size);
    for (int i = 0; i < size; i++) begin
      modelInput[i] = 8'($urandom);
    end
  endtask

  task automatic collectAndCheck(input string label, input int size);
    logic [7:0] got;
    cycleBudget += 20 * size;
    while (rxQueue.size() < size) begin
      @(posedge clock);
    end
    for (int i = 0; i < size; i++) begin
      got = rxQueue.pop_front();
      checkValue($sformatf("%s outStream.data[%0d]", label, i), 32'(got),
                 32'(modelOutput[i]));
    end
  endtask

  task automatic runRelu(input int rows, input int cols, input int channels);
    int size;
    size = rows * cols * channels;
    fillInputs(size);
    reluModel(size);
    queueByte(opRelu);
    queueByte(8'(rows));
    queueByte(8'(cols));
    queueByte(8'(channels));
    for (int i = 0; i < size; i++) begin
      queueByte(modelInput[i]);
    end
    collectAndCheck("relu", size);
  endtask

  task automatic runPool(input int channels, input int outRows, input int outCols,
                         input int windowRows, input int windowCols,
                         input int rowStride, input int colStride);
    int inSize;
    inSize = ((outRows - 1) * rowStride + windowRows) *
             ((outCols - 1) * colStride + windowCols) * channels;
    fillInputs(inSize);
    poolModel(channels, outRows, outCols, windowRows, windowCols, rowStride, colStride);
    queueByte(opPool);
    queueByte(8'(channels));
    queueByte(8'(outRows));
    queueByte(8'(outCols));
    queueByte(8'(windowRows));
    queueByte(8'(windowCols));
    queueByte(8'(rowStride));
    queueByte(8'(colStride));
    for (int i = 0; i < inSize; i++) begin
      queueByte(modelInput[i]);
    end
    collectAndCheck("pool", outRows * outCols * channels);
  endtask

  task automatic randomRelu();
    int rows;
    int cols;
    int maxChannels;
    rows = $urandom_range(1, 8);
    cols = $urandom_range(1, 8);
    maxChannels = 128 / (rows * cols);
    if (maxChannels > 4) begin
      maxChannels = 4;
    end
    runRelu(rows, cols, $urandom_range(1, maxChannels));
  endtask

  // redraw until the input fits below outputBase
  task automatic randomPool(input bit overlap, input bit strideOne);
    int ch;
    int outR;
    int outC;
    int wr;
    int wc;
    int rs;
    int cs;
    int inSize;
    do begin
      ch = $urandom_range(1, 3);
      outR = $urandom_range(1, 4);
      outC = $urandom_range(1, 4);
      if (overlap) begin
        wr = $urandom_range(2, 3);
        wc = $urandom_range(2, 3);
        rs = strideOne ? 1 : $urandom_range(1, wr - 1);
        cs = strideOne ? 1 : $urandom_range(1, wc - 1);
      end else begin
        wr = $urandom_range(1, 3);
        wc = $urandom_range(1, 3);
        rs = wr;
        cs = wc;
      end
      inSize = ((outR - 1) * rs + wr) * ((outC - 1) * cs + wc) * ch;
    end while (inSize > 128);
    runPool(ch, outR, outC, wr, wc, rs, cs);
  endtask

  task automatic queueJunkOpcodes();
    queueByte(8'd0);
    queueByte(8'd1);
    queueByte(8'd4);
    queueByte(8'($urandom_range(5, 255)));
    queueByte(8'($urandom_range(5, 255)));
  endtask

  task automatic finishTest(input string name, input int startErrors);
    if (errorCount == startErrors) begin
      $display("test %s: ok", name);
      passCount++;
    end else begin
      $display("test %s: %0d errors", name, errorCount - startErrors);
      failCount++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : testSequence
    int startErrors;
    void'($urandom(6782));
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    cycleBudget = 0;
    backPressure = 1'b0;
    reset = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;

    startErrors = errorCount;
    repeat (4) randomRelu();
    finishTest("relu", startErrors);

    startErrors = errorCount;
    repeat (4) randomPool(1'b0, 1'b0);
    finishTest("pool without overlap", startErrors);

    startErrors = errorCount;
    repeat (3) randomPool(1'b1, 1'b0);
    randomPool(1'b1, 1'b1);
    finishTest("pool with overlap", startErrors);

    startErrors = errorCount;
    backPressure = 1'b1;
    repeat (2) randomRelu();
    repeat (2) randomPool(1'b1, 1'b0);
    backPressure = 1'b0;
    finishTest("back-pressure", startErrors);

    startErrors = errorCount;
    queueJunkOpcodes();
    randomRelu();
    queueJunkOpcodes();
    randomPool(1'b0, 1'b0);
    finishTest("unknown opcodes", startErrors);

    // every byte should have earned its credit, nothing left over
    startErrors = errorCount;
    while (txQueue.size() != 0) begin
      @(posedge clock);
    end
    repeat (50) @(posedge clock);
    checkValue("input credits", 32'(hostInCredits), 32'(inputCredits));
    checkValue("DUT.streamer.credits", 32'(DUT.streamer.credits), 32'(outputCredits));
    checkValue("extra outStream bytes", 32'(rxQueue.size()), 32'd0);
    finishTest("idle", startErrors);

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog/processingElement.sv ====
`timescale 1ns/1ps

module processingElement import peTypes::*; (
  input logic clock,
  input logic reset,
  input streamByte inStream,
  output logic inCredit,
  output streamByte outStream,
  input logic outCreditReturn
);

  // buffer peers in priority order: parser, pool, relu, streamer
  bufferRequest requests [requesterCount];
  logic [requesterCount-1:0] grants;
  logic signed [dataWidth-1:0] readData;
  layerConfig cfg;
  logic poolStart;
  logic reluStart;
  logic poolDone;
  logic reluDone;
  logic computeDone;
  logic streamDone;

  assign computeDone = poolDone | reluDone;

  commandParser parser (
    .clock(clock),
    .reset(reset),
    .inStream(inStream),
    .inCredit(inCredit),
    .streamDone(streamDone),
    .request(requests[0]),
    .grant(grants[0]),
    .poolStart(poolStart),
    .reluStart(reluStart),
    .cfg(cfg)
  );

  activationBuffer buffer (
    .clock(clock),
    .reset(reset),
    .requests(requests),
    .grants(grants),
    .readData(readData)
  );

  poolEngine pool (
    .clock(clock),
    .reset(reset),
    .start(poolStart),
    .cfg(cfg),
    .request(requests[1]),
    .grant(grants[1]),
    .readData(readData),
    .computeDone(poolDone)
  );

  reluEngine relu (
    .clock(clock),
    .reset(reset),
    .start(reluStart),
    .cfg(cfg),
    .request(requests[2]),
    .grant(grants[2]),
    .readData(readData),
    .computeDone(reluDone)
  );

  resultStreamer streamer (
    .clock(clock),
    .reset(reset),
    .start(computeDone),
    .cfg(cfg),
    .request(requests[3]),
    .grant(grants[3]),
    .readData(readData),
    .outStream(outStream),
    .outCreditReturn(outCreditReturn),
    .streamDone(streamDone)
  );

endmodule

// ==== verilog/resultStreamer.sv ====
`timescale 1ns/1ps

module resultStreamer import peTypes::*; (
  input logic clock,
  input logic reset,
  input logic start,
  input layerConfig cfg,
  output bufferRequest request,
  input logic grant,
  input logic signed [dataWidth-1:0] readData,
  output streamByte outStream,
  input logic outCreditReturn,
  output logic streamDone
);

  typedef enum logic {
    streamIdle,
    streamRead
  } streamState;

  streamState state;
  logic [addressWidth-1:0] readIndex;
  logic [2:0] credits;
  logic pending;
  logic finalPending;
  logic lastRead;

  assign lastRead = 16'(readIndex) == cfg.outputSize - 16'd1;

  // a read spends the credit, so the byte it returns is already covered
  always_comb begin
    request.valid = state == streamRead && credits != 3'd0;
    request.write = 1'b0;
    request.address = outputBase + readIndex;
    request.data = '0;
  end

  always_comb begin
    outStream.valid = pending;
    outStream.data = readData;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= streamIdle;
      credits <= 3'(outputCredits);
      pending <= 1'b0;
      finalPending <= 1'b0;
      streamDone <= 1'b0;
    end else begin
      pending <= grant;
      finalPending <= grant && lastRead;
      streamDone <= pending && finalPending;
      credits <= credits - 3'(grant) + 3'(outCreditReturn);
      case (state)
        streamIdle: begin
          if (start) begin
            state <= streamRead;
          end
        end
        default: begin
          if (grant && lastRead) begin
            state <= streamIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == streamIdle && start) begin
      readIndex <= '0;
    end else if (grant) begin
      readIndex <= readIndex + 1'b1;
    end
  end

  // host returns no more than it was given
  assert property (@(posedge clock) disable iff (reset) credits <= 3'(outputCredits));

endmodule

// ==== verilog/reluEngine.sv ====
`timescale 1ns/1ps

module reluEngine import peTypes::*; (
  input logic clock,
  input logic reset,
  input logic start,
  input layerConfig cfg,
  output bufferRequest request,
  input logic grant,
  input logic signed [dataWidth-1:0] readData,
  output logic computeDone
);

  typedef enum logic [1:0] {
    reluIdle,
    reluRead,
    reluWrite
  } reluState;

  reluState state;
  logic [addressWidth-1:0] elementIndex;
  logic fresh;
  logic signed [dataWidth-1:0] clamped;
  logic signed [dataWidth-1:0] heldValue;
  logic signed [dataWidth-1:0] writeValue;
  logic lastIndex;

  assign clamped = readData[dataWidth-1] ? '0 : readData;
  // readData only lasts a cycle, keep it if the write has to wait
  assign writeValue = fresh ? clamped : heldValue;
  assign lastIndex = 16'(elementIndex) == cfg.inputSize - 16'd1;

  always_comb begin
    request.valid = state != reluIdle;
    request.write = state == reluWrite;
    request.address = (state == reluWrite) ? outputBase + elementIndex : elementIndex;
    request.data = writeValue;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= reluIdle;
      fresh <= 1'b0;
      computeDone <= 1'b0;
    end else begin
      fresh <= grant && state == reluRead;
      computeDone <= grant && state == reluWrite && lastIndex;
      case (state)
        reluIdle: begin
          if (start) begin
            state <= reluRead;
          end
        end
        reluRead: begin
          if (grant) begin
            state <= reluWrite;
          end
        end
        reluWrite: begin
          if (grant) begin
            state <= lastIndex ? reluIdle : reluRead;
          end
        end
        default: state <= reluIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fresh) begin
      heldValue <= clamped;
    end
    if (state == reluIdle && start) begin
      elementIndex <= '0;
    end else if (state == reluWrite && grant) begin
      elementIndex <= elementIndex + 1'b1;
    end
  end

endmodule

// ==== verilog/poolEngine.sv ====
`timescale 1ns/1ps

module poolEngine import peTypes::*; (
  input logic clock,
  input logic reset,
  input logic start,
  input layerConfig cfg,
  output bufferRequest request,
  input logic grant,
  input logic signed [dataWidth-1:0] readData,
  output logic computeDone
);

  typedef enum logic [1:0] {
    poolIdle,
    poolRead,
    poolWrite
  } poolState;

  poolState state;
  logic [7:0] windowCol;
  logic [7:0] windowRow;
  logic [7:0] outCol;
  logic [7:0] outRow;
  logic [7:0] channel;
  logic [15:0] channelBase;
  logic [15:0] inRow;
  logic [15:0] inCol;
  logic [15:0] inAddress;
  logic [addressWidth-1:0] outIndex;
  logic signed [dataWidth-1:0] runningMax;
  logic signed [dataWidth-1:0] updatedMax;
  logic pending;
  logic windowEnd;
  logic lastOutput;

  // input element under the window
  assign inRow = 16'(outRow) * 16'(cfg.rowStride) + 16'(windowRow);
  assign inCol = 16'(outCol) * 16'(cfg.colStride) + 16'(windowCol);
  assign inAddress = channelBase + inRow * cfg.inCols + inCol;

  // fold in the word read last cycle
  assign updatedMax = (pending && readData > runningMax) ? readData : runningMax;

  assign windowEnd = windowCol == cfg.windowCols - 8'd1 && windowRow == cfg.windowRows - 8'd1;
  assign lastOutput = outCol == cfg.outCols - 8'd1 && outRow == cfg.outRows - 8'd1 &&
                      channel == cfg.channels - 8'd1;

  always_comb begin
    request.valid = state != poolIdle;
    request.write = state == poolWrite;
    request.address = (state == poolWrite) ? outputBase + outIndex
                                           : inAddress[addressWidth-1:0];
    request.data = updatedMax;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= poolIdle;
      pending <= 1'b0;
      computeDone <= 1'b0;
    end else begin
      pending <= grant && state == poolRead;
      computeDone <= grant && state == poolWrite && lastOutput;
      case (state)
        poolIdle: begin
          if (start) begin
            state <= poolRead;
          end
        end
        poolRead: begin
          if (grant && windowEnd) begin
            state <= poolWrite;
          end
        end
        poolWrite: begin
          if (grant) begin
            state <= lastOutput ? poolIdle : poolRead;
          end
        end
        default: state <= poolIdle;
      endcase
    end
  end

  // counters, innermost first: window col, window row, out col, out row, channel
  always_ff @(posedge clock) begin
    if (pending) begin
      runningMax <= updatedMax;
    end
    if (state == poolIdle && start) begin
      windowCol <= '0;
      windowRow <= '0;
      outCol <= '0;
      outRow <= '0;
      channel <= '0;
      channelBase <= '0;
      outIndex <= '0;
      runningMax <= mostNegative;
    end else if (state == poolRead && grant) begin
      if (windowCol == cfg.windowCols - 8'd1) begin
        windowCol <= '0;
        windowRow <= (windowRow == cfg.windowRows - 8'd1) ? 8'd0 : windowRow + 8'd1;
      end else begin
        windowCol <= windowCol + 8'd1;
      end
    end else if (state == poolWrite && grant) begin
      // outputs come out in buffer order, so a plain counter addresses them
      runningMax <= mostNegative;
      outIndex <= outIndex + 1'b1;
      if (outCol == cfg.outCols - 8'd1) begin
        outCol <= '0;
        if (outRow == cfg.outRows - 8'd1) begin
          outRow <= '0;
          channel <= channel + 8'd1;
          channelBase <= channelBase + cfg.inRows * cfg.inCols;
        end else begin
          outRow <= outRow + 8'd1;
        end
      end else begin
        outCol <= outCol + 8'd1;
      end
    end
  end

endmodule

// ==== verilog/activationBuffer.sv ====
`timescale 1ns/1ps

module activationBuffer import peTypes::*; (
  input logic clock,
  input logic reset,
  input bufferRequest requests [requesterCount],
  output logic [requesterCount-1:0] grants,
  output logic signed [dataWidth-1:0] readData
);

  logic signed [dataWidth-1:0] memory [bufferDepth];
  bufferRequest selected;

  // fixed priority, lowest index wins
  always_comb begin
    grants = '0;
    selected = '0;
    for (int i = 0; i < requesterCount; i++) begin
      if (requests[i].valid && grants == '0) begin
        grants[i] = 1'b1;
        selected = requests[i];
      end
    end
  end

  // single port, read word lands one cycle after the grant
  always_ff @(posedge clock) begin
    if (selected.valid) begin
      if (selected.write) begin
        memory[selected.address] <= selected.data;
      end else begin
        readData <= memory[selected.address];
      end
    end
  end

  // a peer that is passed over keeps its request up
  for (genvar i = 0; i < requesterCount; i++) begin : holdChecks
    assert property (@(posedge clock) disable iff (reset)
      requests[i].valid && !grants[i] |=> requests[i].valid);
  end

endmodule

// ==== verilog/commandParser.sv ====
`timescale 1ns/1ps

module commandParser import peTypes::*; (
  input logic clock,
  input logic reset,
  input streamByte inStream,
  output logic inCredit,
  input logic streamDone,
  output bufferRequest request,
  input logic grant,
  output logic poolStart,
  output logic reluStart,
  output layerConfig cfg
);

  typedef enum logic [2:0] {
    waitOpcode,
    readDims,
    sizeLayer,
    loadInputs,
    waitStream
  } parserState;

  parserState state;
  logic [dataWidth-1:0] fifoData [inputCredits];
  logic [$clog2(inputCredits)-1:0] writePtr;
  logic [$clog2(inputCredits)-1:0] readPtr;
  logic [$clog2(inputCredits):0] fifoCount;
  logic [dataWidth-1:0] popData;
  logic consume;
  logic pop;
  logic [2:0] dimIndex;
  logic [2:0] lastDim;
  logic [15:0] loadCount;
  logic [15:0] rowSpan;
  logic [15:0] colSpan;
  logic loadDone;

  //////////////////////////////////////////////////////////////////////////////
  // skid FIFO, one credit back per popped byte
  //////////////////////////////////////////////////////////////////////////////

  assign popData = fifoData[readPtr];
  assign pop = fifoCount != '0 && consume;

  always_comb begin
    case (state)
      waitOpcode, readDims: consume = 1'b1;
      // next byte only once the previous write is gone
      loadInputs: consume = !loadDone && (!request.valid || grant);
      default: consume = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (inStream.valid) begin
      fifoData[writePtr] <= inStream.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr <= '0;
      fifoCount <= '0;
      inCredit <= 1'b0;
    end else begin
      if (inStream.valid) begin
        writePtr <= writePtr + 1'b1;
      end
      if (pop) begin
        readPtr <= readPtr + 1'b1;
      end
      fifoCount <= fifoCount + 2'(inStream.valid) - 2'(pop);
      inCredit <= pop;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // command decode and input loading
  //////////////////////////////////////////////////////////////////////////////

  // relu sends three dimensions, pooling seven
  assign lastDim = (cfg.opcode == opPool) ? 3'd6 : 3'd2;
  assign loadDone = loadCount == cfg.inputSize;

  // window and strides are preset to 1 for relu, so inRows comes out as outRows
  assign rowSpan = 16'(cfg.outRows - 8'd1) * 16'(cfg.rowStride) + 16'(cfg.windowRows);
  assign colSpan = 16'(cfg.outCols - 8'd1) * 16'(cfg.colStride) + 16'(cfg.windowCols);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= waitOpcode;
      request.valid <= 1'b0;
      poolStart <= 1'b0;
      reluStart <= 1'b0;
    end else begin
      poolStart <= 1'b0;
      reluStart <= 1'b0;
      if (grant) begin
        request.valid <= 1'b0;
      end
      case (state)
        waitOpcode: begin
          dimIndex <= '0;
          if (pop) begin
            cfg.opcode <= popData;
            cfg.windowRows <= 8'd1;
            cfg.windowCols <= 8'd1;
            cfg.rowStride <= 8'd1;
            cfg.colStride <= 8'd1;
            // anything else is dropped here, its credit already on its way
            if (popData == opPool || popData == opRelu) begin
              state <= readDims;
            end
          end
        end
        readDims: begin
          if (pop) begin
            dimIndex <= dimIndex + 3'd1;
            if (cfg.opcode == opPool) begin
              case (dimIndex)
                3'd0: cfg.channels <= popData;
                3'd1: cfg.outRows <= popData;
                3'd2: cfg.outCols <= popData;
                3'd3: cfg.windowRows <= popData;
                3'd4: cfg.windowCols <= popData;
                3'd5: cfg.rowStride <= popData;
                default: cfg.colStride <= popData;
              endcase
            end else begin
              case (dimIndex)
                3'd0: cfg.outRows <= popData;
                3'd1: cfg.outCols <= popData;
                default: cfg.channels <= popData;
              endcase
            end
            if (dimIndex == lastDim) begin
              state <= sizeLayer;
            end
          end
        end
        sizeLayer: begin
          cfg.inRows <= rowSpan;
          cfg.inCols <= colSpan;
          cfg.inputSize <= rowSpan * colSpan * 16'(cfg.channels);
          cfg.outputSize <= 16'(cfg.outRows) * 16'(cfg.outCols) * 16'(cfg.channels);
          loadCount <= '0;
          state <= loadInputs;
        end
        loadInputs: begin
          if (pop) begin
            request.valid <= 1'b1;
            request.write <= 1'b1;
            request.address <= loadCount[addressWidth-1:0];
            request.data <= popData;
            loadCount <= loadCount + 16'd1;
          end
          if (grant && loadDone) begin
            state <= waitStream;
            poolStart <= cfg.opcode == opPool;
            reluStart <= cfg.opcode == opRelu;
          end
        end
        // one layer in flight, new bytes wait in the FIFO
        waitStream: begin
          if (streamDone) begin
            state <= waitOpcode;
          end
        end
        default: state <= waitOpcode;
      endcase
    end
  end

  // host must never send past its credits
  assert property (@(posedge clock) disable iff (reset)
    !(inStream.valid && fifoCount == inputCredits && !pop));

  // both halves of the buffer must hold the layer
  assert property (@(posedge clock) disable iff (reset)
    state == loadInputs |->
      cfg.inputSize <= 16'(outputBase) && cfg.outputSize <= 16'(outputBase));

endmodule

// ==== verilog/peTypes.sv ====
package peTypes;

  //////////////////////////////////////////////////////////////////////////////
  // sizes and encodings
  //////////////////////////////////////////////////////////////////////////////

  localparam int dataWidth = 8;
  localparam int bufferDepth = 256;
  localparam int addressWidth = 8;
  localparam int requesterCount = 4;

  // inputs live below this address, outputs from here up
  localparam logic [addressWidth-1:0] outputBase = 8'd128;

  localparam logic [dataWidth-1:0] opPool = 8'd2;
  localparam logic [dataWidth-1:0] opRelu = 8'd3;

  // host credits also size the parser skid FIFO
  localparam int inputCredits = 2;
  localparam int outputCredits = 4;

  // seed for the running maximum
  localparam logic signed [dataWidth-1:0] mostNegative = 8'sh80;

  //////////////////////////////////////////////////////////////////////////////
  // shared structs
  //////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic valid;
    logic [dataWidth-1:0] data;
  } streamByte;

  typedef struct packed {
    logic valid;
    logic write;
    logic [addressWidth-1:0] address;
    logic [dataWidth-1:0] data;
  } bufferRequest;

  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] channels;
    logic [7:0] outRows;
    logic [7:0] outCols;
    logic [7:0] windowRows;
    logic [7:0] windowCols;
    logic [7:0] rowStride;
    logic [7:0] colStride;
    // derived by the parser once all dimensions are in
    logic [15:0] inRows;
    logic [15:0] inCols;
    logic [15:0] inputSize;
    logic [15:0] outputSize;
  } layerConfig;

endpackage
